// ==== flist.f ====
design/link_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/thumb_buffer.sv
design/pixel_unpack.sv
design/link_ctrl.sv
design/uart_frame_link.sv
tb/link_chk.sv
tb/tb_uart_frame_link.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_uart_frame_link -f flist.f -o tb_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -qx "ALL CHECKS PASSED"; then
  exit 0
fi
echo "Simulation did not report a pass"
exit 1

// ==== tb/tb_uart_frame_link.sv ====
// Testbench for uart_frame_link at 16 clocks per bit and a 64-byte buffer
// Stimulus from an LCG with a fixed seed, test order chosen by the same LCG
// The first test fills every buffer entry, so later sends read known data
`default_nettype none

module tb_uart_frame_link import link_pkg::*;;

  localparam int CPB          = 16;
  localparam int BUF_DEPTH    = 64;
  localparam int FRAME_CYCLES = 10 * CPB;
  localparam int N_TESTS      = 12;
  // Worst single test is a full store plus a full send
  localparam int TEST_FRAMES  = 2 * BUF_DEPTH + 8;
  localparam int MAX_CYCLES   = ((N_TESTS + 4) * TEST_FRAMES + 200) * FRAME_CYCLES;

  logic      CLOCK_50;
  logic      DLY_RST_0;
  logic      rxd;
  logic      load_sw;
  logic      grey_sw;
  logic      send_n;
  logic      abort_n;
  mem_word_t mem_word;
  logic      txd;
  img_idx_t  cur_img;
  mem_addr_t frame_base;
  color_t    red;
  color_t    green;
  color_t    blue;
  logic      disp_rst_n;
  logic      tx_busy;

  // Reference model
  img_idx_t    exp_img;
  logic        exp_grey;
  byte_t       model_buf [BUF_DEPTH];
  int          store_ptr;
  logic [31:0] rng_state;

  int checks;
  int mismatches;
  int failures;
  int rst_low_cycles = 0;
  int cycle_count = 0;

  uart_frame_link #(
    .CLKS_PER_BIT (CPB),
    .BUF_DEPTH    (BUF_DEPTH)
  ) u_uart_frame_link (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .rxd        (rxd),
    .load_sw    (load_sw),
    .grey_sw    (grey_sw),
    .send_n     (send_n),
    .abort_n    (abort_n),
    .mem_word   (mem_word),
    .txd        (txd),
    .cur_img    (cur_img),
    .frame_base (frame_base),
    .red        (red),
    .green      (green),
    .blue       (blue),
    .disp_rst_n (disp_rst_n),
    .tx_busy    (tx_busy)
  );

  always #10 CLOCK_50 = ~CLOCK_50;

  // Cycles with the display reset low, one per correct pulse
  always @(posedge CLOCK_50) begin
    if (DLY_RST_0 && disp_rst_n === 1'b0) begin
      rst_low_cycles <= rst_low_cycles + 1;
    end
  end

  always @(posedge CLOCK_50) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == MAX_CYCLES) begin
      $display("error: run did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // ====================
  // Helpers
  // ====================

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int unsigned rand_range(input int unsigned n);
    logic [31:0] r;
    r = next_rand();
    return (r >> 16) % n;
  endfunction

  // Frame map rule applied to the model state, one stride per image index
  function automatic mem_addr_t expected_base();
    mem_addr_t base;
    if (exp_grey) begin
      return GREY_BASE;
    end
    base = IMG_BASE;
    for (int i = 0; i < int'(exp_img); i++) begin
      base = base + IMG_STRIDE;
    end
    return base;
  endfunction

  task automatic check_byte(input string name, input byte_t exp, input byte_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input mem_addr_t exp, input mem_addr_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_color(input string name, input color_t exp, input color_t act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      mismatches++;
      $display("mismatch at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("error at %0t: %s", $time, what);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge CLOCK_50);
  endtask

  // ====================
  // Serial line model
  // ====================

  // 8N1, LSB first, called right after a rising edge
  task automatic drive_frame(input byte_t b);
    logic [9:0] bits;
    bits = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      rxd <= bits[i];
      repeat (CPB) @(posedge CLOCK_50);
    end
  endtask

  // Samples each bit near its middle, optionally presses abort at the start bit
  task automatic receive_frame(input logic abort_now, output byte_t b, output logic ok);
    int waited;
    ok = 1'b0;
    b = '0;
    waited = 0;
    @(posedge CLOCK_50);
    while (txd !== 1'b0 && waited < 2 * FRAME_CYCLES) begin
      @(posedge CLOCK_50);
      waited++;
    end
    if (txd !== 1'b0) begin
      report_failure("no start bit appeared on txd");
      return;
    end
    if (abort_now) begin
      abort_n <= 1'b0;
    end
    repeat (CPB / 2) @(posedge CLOCK_50);
    if (txd !== 1'b0) begin
      report_failure("start bit on txd ended early");
      return;
    end
    for (int i = 0; i < 8; i++) begin
      repeat (CPB) @(posedge CLOCK_50);
      b[i] = txd;
    end
    repeat (CPB) @(posedge CLOCK_50);
    if (txd !== 1'b1) begin
      report_failure("stop bit on txd was low");
      return;
    end
    ok = 1'b1;
  endtask

  task automatic start_send(output logic ok);
    int waited;
    waited = 0;
    send_n <= 1'b0;
    @(posedge CLOCK_50);
    while (tx_busy !== 1'b1 && waited < 20) begin
      @(posedge CLOCK_50);
      waited++;
    end
    send_n <= 1'b1;
    ok = (tx_busy === 1'b1);
    if (!ok) begin
      report_failure("tx_busy did not rise after the send key press");
    end
  endtask

  task automatic wait_busy_low(input int limit, input string what);
    int waited;
    waited = 0;
    while (tx_busy !== 1'b0 && waited < limit) begin
      @(posedge CLOCK_50);
      waited++;
    end
    if (tx_busy !== 1'b0) begin
      report_failure({"tx_busy stayed high ", what});
    end
  endtask

  // ====================
  // Tests
  // ====================

  task automatic test_select();
    byte_t b;
    int    low_before;
    int    exp_low;
    if (rand_range(4) == 0) begin
      b = exp_img;
    end else begin
      b = byte_t'(rand_range(256));
    end
    load_sw <= 1'b0;
    low_before = rst_low_cycles;
    drive_frame(b);
    wait_cycles(8);
    exp_low = (b != exp_img) ? 1 : 0;
    exp_img = b;
    check_byte("cur_img", exp_img, cur_img);
    check_addr("frame_base", expected_base(), frame_base);
    check_count("disp_rst_n low cycles", exp_low, rst_low_cycles - low_before);
  endtask

  task automatic test_pixel();
    logic [31:0] r;
    mem_word_t   w;
    logic        g;
    int          low_before;
    r = next_rand();
    w = mem_word_t'(r >> 8);
    g = r[27];
    low_before = rst_low_cycles;
    mem_word <= w;
    grey_sw  <= g;
    wait_cycles(6);
    @(negedge CLOCK_50);
    check_count("disp_rst_n low cycles", (g != exp_grey) ? 1 : 0,
                rst_low_cycles - low_before);
    exp_grey = g;
    check_addr("frame_base", expected_base(), frame_base);
    if (g) begin
      check_color("red", w[11:2], red);
      check_color("green", w[11:2], green);
      check_color("blue", w[11:2], blue);
    end else begin
      check_color("red", color_t'(w[7:5]) << 7, red);
      check_color("green", color_t'(w[4:2]) << 7, green);
      check_color("blue", color_t'(w[1:0]) << 8, blue);
    end
    @(posedge CLOCK_50);
  endtask

  task automatic store_bytes(input int count);
    byte_t b;
    load_sw <= 1'b1;
    for (int i = 0; i < count; i++) begin
      b = byte_t'(rand_range(256));
      drive_frame(b);
      model_buf[store_ptr] = b;
      store_ptr = (store_ptr + 1) % BUF_DEPTH;
    end
    wait_cycles(8);
    load_sw <= 1'b0;
  endtask

  task automatic test_send();
    byte_t got;
    logic  ok;
    store_bytes(BUF_DEPTH);
    start_send(ok);
    if (!ok) begin
      return;
    end
    for (int i = 0; i < BUF_DEPTH; i++) begin
      receive_frame(1'b0, got, ok);
      if (!ok) begin
        return;
      end
      check_byte("txd byte", model_buf[i], got);
    end
    wait_busy_low(FRAME_CYCLES, "after the last byte");
  endtask

  task automatic test_abort();
    int    k;
    int    line_low;
    byte_t got;
    logic  ok;
    k = rand_range(4);
    line_low = 0;
    start_send(ok);
    if (!ok) begin
      return;
    end
    // Abort pressed at the start bit of byte k
    for (int i = 0; i <= k; i++) begin
      receive_frame(i == k, got, ok);
      if (!ok) begin
        break;
      end
      check_byte("txd byte", model_buf[i], got);
    end
    wait_busy_low(4, "after the abort key press");
    for (int i = 0; i < 2 * FRAME_CYCLES; i++) begin
      @(posedge CLOCK_50);
      if (txd !== 1'b1) begin
        line_low++;
      end
    end
    if (line_low != 0) begin
      report_failure("txd left idle after the aborted byte");
    end
    abort_n <= 1'b1;
    wait_cycles(4);
  endtask

  // ====================
  // Main sequence
  // ====================

  initial begin
    CLOCK_50   = 1'b0;
    DLY_RST_0  = 1'b0;
    rxd        = 1'b1;
    load_sw    = 1'b0;
    grey_sw    = 1'b0;
    send_n     = 1'b1;
    abort_n    = 1'b1;
    mem_word   = '0;
    rng_state  = 32'h9e1;
    exp_img    = '0;
    exp_grey   = 1'b0;
    store_ptr  = 0;
    checks     = 0;
    mismatches = 0;
    failures   = 0;

    repeat (8) @(posedge CLOCK_50);
    DLY_RST_0 <= 1'b1;
    wait_cycles(2);

    // Idle state after reset
    check_byte("cur_img", '0, cur_img);
    check_addr("frame_base", expected_base(), frame_base);
    check_bit("disp_rst_n", 1'b1, disp_rst_n);
    check_bit("tx_busy", 1'b0, tx_busy);
    check_bit("txd", 1'b1, txd);

    // Each kind of test once, then a random order
    test_send();
    test_select();
    test_pixel();
    test_abort();
    for (int t = 0; t < N_TESTS; t++) begin
      case (rand_range(5))
        0:       test_select();
        1:       test_pixel();
        2:       store_bytes(1 + int'(rand_range(7)));
        3:       test_send();
        default: test_abort();
      endcase
    end
    wait_cycles(4);

    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb/link_chk.sv ====
// Protocol checks on link_ctrl, attached by bind
// Checks are disabled while DLY_RST_0 is low
`default_nettype none

module link_chk import link_pkg::*; (
  input logic     CLOCK_50,
  input logic     DLY_RST_0,
  input img_idx_t cur_img,
  input logic     grey_sw,
  input logic     disp_rst_n,
  input logic     tx_start,
  input logic     tx_done,
  input logic     buf_we
);

  // A byte handed to uart_tx and not yet finished
  logic frame_open;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      frame_open <= 1'b0;
    end else if (tx_start) begin
      frame_open <= 1'b1;
    end else if (tx_done) begin
      frame_open <= 1'b0;
    end
  end

  // A display change outside a pulse starts a pulse on the next cycle
  a_disp_on_change: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0)
      ((cur_img != $past(cur_img)) || (grey_sw != $past(grey_sw))) && disp_rst_n
      |=> !disp_rst_n
  ) else $error("no disp_rst_n pulse after a change of cur_img or grey_sw");

  // Transmit start only once the previous byte is finished
  a_start_after_done: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) tx_start |-> !frame_open
  ) else $error("tx_start pulsed before tx_done of the previous byte");

  // A stored byte never selects an image
  a_store_keeps_img: assert property (
    @(posedge CLOCK_50) disable iff (!DLY_RST_0) buf_we |=> $stable(cur_img)
  ) else $error("cur_img changed on a byte stored in load mode");

endmodule

bind link_ctrl link_chk u_link_chk (
  .CLOCK_50   (CLOCK_50),
  .DLY_RST_0  (DLY_RST_0),
  .cur_img    (cur_img),
  .grey_sw    (grey_sw),
  .disp_rst_n (disp_rst_n),
  .tx_start   (tx_start),
  .tx_done    (tx_done),
  .buf_we     (buf_we)
);

`default_nettype wire

// ==== design/uart_frame_link.sv ====
// Serial image link, top level
// CLKS_PER_BIT is the clock rate over the baud rate, 434 for 115200 at 50 MHz
// BUF_DEPTH is the thumbnail length in bytes
// mem_word is the frame-buffer word read at frame_base by the display side
`default_nettype none

module uart_frame_link import link_pkg::*; #(
  parameter int CLKS_PER_BIT = 434,
  parameter int BUF_DEPTH    = 1024
) (
  input  logic      CLOCK_50,
  input  logic      DLY_RST_0,
  input  logic      rxd,
  input  logic      load_sw,
  input  logic      grey_sw,
  input  logic      send_n,
  input  logic      abort_n,
  input  mem_word_t mem_word,
  output logic      txd,
  output img_idx_t  cur_img,
  output mem_addr_t frame_base,
  output color_t    red,
  output color_t    green,
  output color_t    blue,
  output logic      disp_rst_n,
  output logic      tx_busy
);

  localparam int AW = $clog2(BUF_DEPTH);

  logic          rx_valid;
  byte_t         rx_byte;
  logic          buf_we;
  logic [AW-1:0] buf_waddr;
  logic [AW-1:0] buf_raddr;
  byte_t         buf_rdata;
  logic          tx_start;
  logic          tx_done;

  uart_rx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_rx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .rxd       (rxd),
    .rx_valid  (rx_valid),
    .rx_byte   (rx_byte)
  );

  link_ctrl #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_link_ctrl (
    .CLOCK_50   (CLOCK_50),
    .DLY_RST_0  (DLY_RST_0),
    .load_sw    (load_sw),
    .grey_sw    (grey_sw),
    .send_n     (send_n),
    .abort_n    (abort_n),
    .rx_valid   (rx_valid),
    .rx_byte    (rx_byte),
    .tx_done    (tx_done),
    .buf_we     (buf_we),
    .buf_waddr  (buf_waddr),
    .buf_raddr  (buf_raddr),
    .tx_start   (tx_start),
    .cur_img    (cur_img),
    .disp_rst_n (disp_rst_n),
    .tx_busy    (tx_busy)
  );

  // Received bytes go straight into the buffer
  thumb_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_thumb_buffer (
    .CLOCK_50  (CLOCK_50),
    .buf_we    (buf_we),
    .buf_waddr (buf_waddr),
    .buf_wdata (rx_byte),
    .buf_raddr (buf_raddr),
    .buf_rdata (buf_rdata)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .CLOCK_50  (CLOCK_50),
    .DLY_RST_0 (DLY_RST_0),
    .tx_start  (tx_start),
    .tx_byte   (buf_rdata),
    .txd       (txd),
    .tx_done   (tx_done)
  );

  pixel_unpack u_pixel_unpack (
    .cur_img    (cur_img),
    .grey_sw    (grey_sw),
    .mem_word   (mem_word),
    .frame_base (frame_base),
    .red        (red),
    .green      (green),
    .blue       (blue)
  );

endmodule

`default_nettype wire

// ==== design/link_ctrl.sv ====
// Link control: image select, thumbnail store pointer, send sequencing
// and the display reset pulse
// send_n and abort_n are asynchronous keys, synchronized here
// A send starts on the press of send_n, abort_n held low keeps it stopped
// Store pointer wraps at BUF_DEPTH, received bytes are never held back
`default_nettype none

module link_ctrl import link_pkg::*; #(
  parameter  int BUF_DEPTH = 1024,
  localparam int AW        = $clog2(BUF_DEPTH)
) (
  input  logic          CLOCK_50,
  input  logic          DLY_RST_0,
  input  logic          load_sw,
  input  logic          grey_sw,
  input  logic          send_n,
  input  logic          abort_n,
  input  logic          rx_valid,
  input  byte_t         rx_byte,
  input  logic          tx_done,
  output logic          buf_we,
  output logic [AW-1:0] buf_waddr,
  output logic [AW-1:0] buf_raddr,
  output logic          tx_start,
  output img_idx_t      cur_img,
  output logic          disp_rst_n,
  output logic          tx_busy
);

  localparam logic [AW-1:0] PTR_LAST = AW'(BUF_DEPTH - 1);

  typedef enum logic [1:0] {IDLE, FETCH, START, WAIT} send_state_t;

  send_state_t   state;
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          send_meta;
  logic          send_sync;
  logic          send_prev;
  logic          abort_meta;
  logic          abort_sync;
  logic          send_press;
  img_idx_t      prev_img;
  logic          prev_grey;
  logic          disp_changed;

  // ====================
  // Receive side
  // ====================

  // Image select only while not loading
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      cur_img <= '0;
    end else if (rx_valid && !load_sw) begin
      cur_img <= rx_byte;
    end
  end

  assign buf_we    = rx_valid && load_sw;
  assign buf_waddr = wr_ptr;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      wr_ptr <= '0;
    end else if (buf_we) begin
      wr_ptr <= (wr_ptr == PTR_LAST) ? '0 : wr_ptr + 1'b1;
    end
  end

  // ====================
  // Send side
  // ====================

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      send_meta  <= 1'b1;
      send_sync  <= 1'b1;
      send_prev  <= 1'b1;
      abort_meta <= 1'b1;
      abort_sync <= 1'b1;
    end else begin
      send_meta  <= send_n;
      send_sync  <= send_meta;
      send_prev  <= send_sync;
      abort_meta <= abort_n;
      abort_sync <= abort_meta;
    end
  end

  assign send_press = send_prev && !send_sync;

  // rd_ptr doubles as the count of bytes sent
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state  <= IDLE;
      rd_ptr <= '0;
    end else if (!abort_sync) begin
      // uart_tx finishes any byte already on the line
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (send_press) begin
            rd_ptr <= '0;
            state  <= FETCH;
          end
        end
        FETCH: state <= START;
        START: state <= WAIT;
        WAIT: begin
          if (tx_done) begin
            if (rd_ptr == PTR_LAST) begin
              state <= IDLE;
            end else begin
              rd_ptr <= rd_ptr + 1'b1;
              state  <= FETCH;
            end
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Buffer read data is valid during START
  assign buf_raddr = rd_ptr;
  assign tx_start  = (state == START);
  assign tx_busy   = (state != IDLE);

  // ====================
  // Display reset
  // ====================

  assign disp_changed = (cur_img != prev_img) || (grey_sw != prev_grey);

  // A change right after a pulse waits one cycle for its own pulse
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      prev_img   <= '0;
      prev_grey  <= 1'b0;
      disp_rst_n <= 1'b1;
    end else if (disp_changed && disp_rst_n) begin
      prev_img   <= cur_img;
      prev_grey  <= grey_sw;
      disp_rst_n <= 1'b0;
    end else begin
      disp_rst_n <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== design/pixel_unpack.sv ====
// Frame base address and pixel expansion for the display
// Purely combinational
// Stored images are RGB332 in the low byte of each word
// The grey frame keeps 12-bit sensor data in bits 11 to 0
`default_nettype none

module pixel_unpack import link_pkg::*; (
  input  img_idx_t  cur_img,
  input  logic      grey_sw,
  input  mem_word_t mem_word,
  output mem_addr_t frame_base,
  output color_t    red,
  output color_t    green,
  output color_t    blue
);

  mem_addr_t img_offset;
  color_t    grey;

  // One frame of words per image index
  assign img_offset = IMG_STRIDE * mem_addr_t'(cur_img);

  assign frame_base = grey_sw ? GREY_BASE : IMG_BASE + img_offset;

  // Top 10 of the 12 sensor bits
  assign grey = mem_word[11:2];

  // ====================
  // Channel expansion
  // ====================

  always_comb begin
    if (grey_sw) begin
      red   = grey;
      green = grey;
      blue  = grey;
    end else begin
      // RGB332 bits land at the top of each channel
      red   = {mem_word[7:5], 7'd0};
      green = {mem_word[4:2], 7'd0};
      blue  = {mem_word[1:0], 8'd0};
    end
  end

endmodule

`default_nettype wire

// ==== design/thumb_buffer.sv ====
// Thumbnail byte store, one write port and one read port
// Read data appears one cycle after the read address
// Contents are undefined until written
`default_nettype none

module thumb_buffer import link_pkg::*; #(
  parameter  int BUF_DEPTH = 1024,
  localparam int AW        = $clog2(BUF_DEPTH)
) (
  input  logic          CLOCK_50,
  input  logic          buf_we,
  input  logic [AW-1:0] buf_waddr,
  input  byte_t         buf_wdata,
  input  logic [AW-1:0] buf_raddr,
  output byte_t         buf_rdata
);

  byte_t mem [BUF_DEPTH];

  // Maps onto block RAM
  always_ff @(posedge CLOCK_50) begin
    if (buf_we) begin
      mem[buf_waddr] <= buf_wdata;
    end
    buf_rdata <= mem[buf_raddr];
  end

endmodule

`default_nettype wire

// ==== design/uart_tx.sv ====
// 8N1 UART transmitter, LSB first
// tx_start is taken only while the line is idle
// tx_done pulses for one cycle at the end of the stop bit
`default_nettype none

module uart_tx import link_pkg::*; #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  CLOCK_50,
  input  logic  DLY_RST_0,
  input  logic  tx_start,
  input  byte_t tx_byte,
  output logic  txd,
  output logic  tx_done
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CW-1:0] BIT_LAST = CW'(CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} tx_state_t;

  tx_state_t     state;
  logic [CW-1:0] clk_cnt;
  logic [2:0]    bit_idx;
  byte_t         shifter;

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state   <= IDLE;
      clk_cnt <= '0;
      bit_idx <= '0;
      tx_done <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (state == IDLE) begin
        clk_cnt <= '0;
        bit_idx <= '0;
        if (tx_start) begin
          state <= START;
        end
      end else if (clk_cnt != BIT_LAST) begin
        clk_cnt <= clk_cnt + 1'b1;
      end else begin
        // End of one bit period
        clk_cnt <= '0;
        case (state)
          START: state <= DATA;
          DATA: begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= STOP;
            end
          end
          default: begin
            state   <= IDLE;
            tx_done <= 1'b1;
          end
        endcase
      end
    end
  end

  // Byte held for the whole frame, shifted out LSB first
  always_ff @(posedge CLOCK_50) begin
    if (state == IDLE && tx_start) begin
      shifter <= tx_byte;
    end else if (state == DATA && clk_cnt == BIT_LAST) begin
      shifter <= {1'b0, shifter[7:1]};
    end
  end

  // Line is high except for the start bit and the data bits
  always_comb begin
    case (state)
      START:   txd = 1'b0;
      DATA:    txd = shifter[0];
      default: txd = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== design/uart_rx.sv ====
// 8N1 UART receiver, LSB first
// rxd is asynchronous and goes through a two-flop synchronizer
// Bits are sampled near their middle, CLKS_PER_BIT must be at least 4
// A frame with a low stop bit is dropped without a pulse
`default_nettype none

module uart_rx import link_pkg::*; #(
  parameter int CLKS_PER_BIT = 434
) (
  input  logic  CLOCK_50,
  input  logic  DLY_RST_0,
  input  logic  rxd,
  output logic  rx_valid,
  output byte_t rx_byte
);

  localparam int CW = $clog2(CLKS_PER_BIT + 1);
  localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);

  typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

  rx_state_t       state;
  logic [CW-1:0]   clk_cnt;
  logic [2:0]      bit_idx;
  logic            rx_meta;
  logic            rx_sync;
  logic            rx_prev;
  byte_t           shift_reg;

  // Input synchronizer plus one more stage for the start edge
  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rxd;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge CLOCK_50 or negedge DLY_RST_0) begin
    if (!DLY_RST_0) begin
      state    <= IDLE;
      clk_cnt  <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        IDLE: begin
          clk_cnt <= '0;
          if (rx_prev && !rx_sync) begin
            state <= START;
          end
        end
        // Half a bit, then confirm the line is still low
        START: begin
          if (clk_cnt == HALF_LAST) begin
            clk_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? IDLE : DATA;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        DATA: begin
          if (clk_cnt == BIT_LAST) begin
            clk_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= STOP;
            end
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        STOP: begin
          if (clk_cnt == BIT_LAST) begin
            rx_valid <= rx_sync;
            state    <= IDLE;
          end else begin
            clk_cnt <= clk_cnt + 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Data bits arrive LSB first
  always_ff @(posedge CLOCK_50) begin
    if (state == DATA && clk_cnt == BIT_LAST) begin
      shift_reg <= {rx_sync, shift_reg[7:1]};
    end
  end

  assign rx_byte = shift_reg;

endmodule

`default_nettype wire

// ==== design/link_pkg.sv ====
// Shared types and frame-buffer constants for the serial image link
// Addresses are frame-buffer word addresses, not byte addresses
// IMG_STRIDE fits one 640x480 frame of 16-bit words per stored image
`default_nettype none

package link_pkg;

  // ====================
  // Data widths
  // ====================

  // One byte on the serial line
  typedef logic [7:0] byte_t;

  // Stored image number, as received over the link
  typedef logic [7:0] img_idx_t;

  // Frame-buffer word address
  typedef logic [22:0] mem_addr_t;

  // Frame-buffer data word
  typedef logic [15:0] mem_word_t;

  // Display channel, 10 bits per color
  typedef logic [9:0] color_t;

  // ====================
  // Frame map
  // ====================

  // First stored image
  localparam mem_addr_t IMG_BASE = 23'h100000;

  // Words per stored image, 640 x 480
  localparam mem_addr_t IMG_STRIDE = 23'h04B000;

  // Live grey frame from the camera path
  localparam mem_addr_t GREY_BASE = 23'h000000;

endpackage

`default_nettype wire
